// ==== verilog/boot_pkg.sv ====
package boot_pkg;

  localparam int word_w = 32;        // instruction and outdata width.
  localparam int byte_w = 8;         // one uart data byte.
  localparam int bytes_per_word = 4; // bytes per loaded word, lsb first.

  // byte assembler: collect bytes, then one write cycle.
  typedef enum logic {
    IDLE,
    SET
  } load_state_t;

  // word serializer on the transmit side.
  typedef enum logic [1:0] {
    STEADY,
    SPLIT,
    SEND
  } send_state_t;

  // receiver phases, the transmitter walks the same frame phases.
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

endpackage

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx #(
  parameter int clks_per_bit = 434
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        rx,
  input  logic                        clr_rx_rdy,
  output logic                        rx_rdy,
  output logic [boot_pkg::byte_w-1:0] rx_data
);

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam int bit_w = $clog2(boot_pkg::byte_w);
  localparam logic [cnt_w-1:0] bit_end = cnt_w'(clks_per_bit - 1);
  localparam logic [cnt_w-1:0] half_end = cnt_w'(clks_per_bit / 2 - 1);
  localparam logic [bit_w-1:0] last_bit = bit_w'(boot_pkg::byte_w - 1);

  boot_pkg::rx_state_t state;
  logic [1:0]          rx_sync;
  logic                rx_s;
  logic [cnt_w-1:0]    baud_cnt;
  logic [bit_w-1:0]    bit_cnt;
  logic                stop_err; // stop bit was low, wait for idle line.
  logic                sample;
  logic                stop_ok;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      rx_sync <= 2'b11; // line idles high.
    else
      rx_sync <= {rx_sync[0], rx};
  end

  assign rx_s = rx_sync[1];

  assign sample = (state == boot_pkg::RX_DATA) && (baud_cnt == bit_end);
  assign stop_ok = (state == boot_pkg::RX_STOP) && !stop_err && (baud_cnt == bit_end) && rx_s;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state    <= boot_pkg::RX_IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      stop_err <= 1'b0;
    end else begin
      baud_cnt <= baud_cnt + cnt_w'(1);
      case (state)
        boot_pkg::RX_IDLE: begin
          baud_cnt <= '0;
          if (!rx_s)
            state <= boot_pkg::RX_START;
        end
        boot_pkg::RX_START: begin
          if (baud_cnt == half_end) begin // middle of start bit.
            baud_cnt <= '0;
            bit_cnt  <= '0;
            if (rx_s)
              state <= boot_pkg::RX_IDLE; // glitch, not a start bit.
            else
              state <= boot_pkg::RX_DATA;
          end
        end
        boot_pkg::RX_DATA: begin
          if (sample) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + bit_w'(1);
            if (bit_cnt == last_bit)
              state <= boot_pkg::RX_STOP;
          end
        end
        boot_pkg::RX_STOP: begin
          if (stop_err) begin
            baud_cnt <= '0;
            if (rx_s) begin
              stop_err <= 1'b0;
              state    <= boot_pkg::RX_IDLE;
            end
          end else if (baud_cnt == bit_end) begin
            baud_cnt <= '0;
            if (rx_s)
              state <= boot_pkg::RX_IDLE;
            else
              stop_err <= 1'b1; // framing error, byte is dropped.
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sample)
      rx_data <= {rx_s, rx_data[boot_pkg::byte_w-1:1]}; // lsb arrives first.
  end

  // a new byte wins over a clear in the same cycle.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      rx_rdy <= 1'b0;
    else if (stop_ok)
      rx_rdy <= 1'b1;
    else if (clr_rx_rdy)
      rx_rdy <= 1'b0;
  end

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx #(
  parameter int clks_per_bit = 434
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        trmt,
  input  logic [boot_pkg::byte_w-1:0] tx_data,
  output logic                        tx,
  output logic                        tx_done
);

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam int bit_w = $clog2(boot_pkg::byte_w);
  localparam int frame_w = boot_pkg::byte_w + 2;
  localparam logic [cnt_w-1:0] bit_end = cnt_w'(clks_per_bit - 1);
  localparam logic [bit_w-1:0] last_bit = bit_w'(boot_pkg::byte_w - 1);

  boot_pkg::rx_state_t state;
  logic [cnt_w-1:0]    baud_cnt;
  logic [bit_w-1:0]    bit_cnt;
  logic [frame_w-1:0]  shreg; // stop, data, start.
  logic                bit_done;

  assign bit_done = (baud_cnt == bit_end);
  assign tx = shreg[0];

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state    <= boot_pkg::RX_IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      shreg    <= '1; // idle line.
      tx_done  <= 1'b0;
    end else begin
      tx_done <= 1'b0;
      if (state == boot_pkg::RX_IDLE) begin
        baud_cnt <= '0;
        if (trmt) begin
          shreg <= {1'b1, tx_data, 1'b0};
          state <= boot_pkg::RX_START;
        end
      end else if (bit_done) begin
        baud_cnt <= '0;
        shreg    <= {1'b1, shreg[frame_w-1:1]};
        case (state)
          boot_pkg::RX_START: begin
            bit_cnt <= '0;
            state   <= boot_pkg::RX_DATA;
          end
          boot_pkg::RX_DATA: begin
            bit_cnt <= bit_cnt + bit_w'(1);
            if (bit_cnt == last_bit)
              state <= boot_pkg::RX_STOP;
          end
          default: begin // end of stop bit.
            state   <= boot_pkg::RX_IDLE;
            tx_done <= 1'b1;
          end
        endcase
      end else begin
        baud_cnt <= baud_cnt + cnt_w'(1);
      end
    end
  end

endmodule

// ==== verilog/word_fifo.sv ====
`timescale 1ns/1ps

module word_fifo #(
  parameter int q_depth = 8
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        add,
  input  logic                        remove,
  input  logic [boot_pkg::word_w-1:0] data_in,
  output logic [boot_pkg::word_w-1:0] data_out,
  output logic                        q_empty
);

  localparam int addr_w = $clog2(q_depth);

  logic [boot_pkg::word_w-1:0] mem [q_depth];
  logic [addr_w:0]             wr_ptr; // extra msb tells full from empty.
  logic [addr_w:0]             rd_ptr;
  logic                        q_full;
  logic                        push;
  logic                        pop;

  assign q_empty = (wr_ptr == rd_ptr);
  assign q_full = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                  (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

  assign push = add && !q_full;     // push into a full queue is lost.
  assign pop = remove && !q_empty;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + (addr_w + 1)'(1);
      if (pop)
        rd_ptr <= rd_ptr + (addr_w + 1)'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr[addr_w-1:0]] <= data_in;
  end

  assign data_out = mem[rd_ptr[addr_w-1:0]]; // head word.

endmodule

// ==== verilog/bootloader.sv ====
`timescale 1ns/1ps

module bootloader #(
  parameter int q_depth = 8
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        debug,
  input  logic                        rx_rdy,
  input  logic [boot_pkg::byte_w-1:0] rx_data,
  output logic                        clr_rx_rdy,
  output logic                        trmt,
  output logic [boot_pkg::byte_w-1:0] tx_data,
  input  logic                        tx_done,
  input  logic [boot_pkg::word_w-1:0] outdata,
  input  logic                        write,
  output logic [boot_pkg::word_w-1:0] addr,
  output logic [boot_pkg::word_w-1:0] data,
  output logic                        increment
);

  localparam int cnt_w = $clog2(boot_pkg::bytes_per_word);
  localparam logic [cnt_w-1:0] last_byte = cnt_w'(boot_pkg::bytes_per_word - 1);

  boot_pkg::load_state_t       load_state;
  boot_pkg::load_state_t       load_nxt;
  logic [cnt_w-1:0]            byte_cnt;
  logic                        shift_in;

  boot_pkg::send_state_t       send_state;
  boot_pkg::send_state_t       send_nxt;
  logic [cnt_w-1:0]            tx_cnt;  // frames finished in this word.
  logic [boot_pkg::word_w-1:0] tx_word;
  logic [boot_pkg::word_w-1:0] fifo_out;
  logic                        q_empty;
  logic                        remove;
  logic                        frame_end;

  // load path.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      load_state <= boot_pkg::IDLE;
    else
      load_state <= load_nxt;
  end

  always_comb begin
    load_nxt = load_state;
    shift_in = 1'b0;
    case (load_state)
      boot_pkg::IDLE: begin
        if (debug && rx_rdy) begin
          shift_in = 1'b1;
          if (byte_cnt == last_byte)
            load_nxt = boot_pkg::SET;
        end
      end
      default: load_nxt = boot_pkg::IDLE;
    endcase
  end

  assign increment = (load_state == boot_pkg::SET); // imem write enable.
  assign clr_rx_rdy = shift_in;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      byte_cnt <= '0;
    else if (!debug)
      byte_cnt <= '0; // drop a partial word.
    else if (shift_in)
      byte_cnt <= byte_cnt + cnt_w'(1);
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      data <= '0;
    else if (shift_in)
      data <= {rx_data, data[boot_pkg::word_w-1:boot_pkg::byte_w]};
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      addr <= '0;
    else if (!debug)
      addr <= '0;
    else if (increment)
      addr <= addr + boot_pkg::word_w'(1);
  end

  // send path.
  word_fifo #(
    .q_depth(q_depth)
  ) u_queue (
    .clk     (clk),
    .rst_n   (rst_n),
    .add     (write),
    .remove  (remove),
    .data_in (outdata),
    .data_out(fifo_out),
    .q_empty (q_empty)
  );

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      send_state <= boot_pkg::STEADY;
    else
      send_state <= send_nxt;
  end

  assign frame_end = (send_state == boot_pkg::SEND) && tx_done;

  always_comb begin
    send_nxt = send_state;
    remove   = 1'b0;
    trmt     = 1'b0;
    case (send_state)
      boot_pkg::STEADY: begin
        if (!q_empty) begin
          remove   = 1'b1;
          send_nxt = boot_pkg::SPLIT;
        end
      end
      boot_pkg::SPLIT: begin
        trmt     = 1'b1; // first byte.
        send_nxt = boot_pkg::SEND;
      end
      boot_pkg::SEND: begin
        if (tx_done) begin
          if (tx_cnt == last_byte)
            send_nxt = boot_pkg::STEADY;
          else
            trmt = 1'b1;
        end
      end
      default: send_nxt = boot_pkg::STEADY;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      tx_cnt <= '0;
    else if (frame_end)
      tx_cnt <= tx_cnt + cnt_w'(1); // wraps back to 0 after the last byte.
  end

  // next byte moves down once the current one is handed to the uart.
  always_ff @(posedge clk) begin
    if (remove)
      tx_word <= fifo_out;
    else if (trmt)
      tx_word <= {boot_pkg::byte_w'(0), tx_word[boot_pkg::word_w-1:boot_pkg::byte_w]};
  end

  assign tx_data = tx_word[boot_pkg::byte_w-1:0];

endmodule

// ==== verilog/boot_top.sv ====
`timescale 1ns/1ps

module boot_top #(
  parameter int clks_per_bit = 434,
  parameter int q_depth      = 8
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        debug,
  input  logic                        rx,
  output logic                        tx,
  input  logic [boot_pkg::word_w-1:0] outdata,
  input  logic                        write,
  output logic [boot_pkg::word_w-1:0] addr,
  output logic [boot_pkg::word_w-1:0] data,
  output logic                        increment
);

  logic                        rx_rdy;
  logic [boot_pkg::byte_w-1:0] rx_data;
  logic                        clr_rx_rdy;
  logic                        trmt;
  logic [boot_pkg::byte_w-1:0] tx_data;
  logic                        tx_done;

  uart_rx #(
    .clks_per_bit(clks_per_bit)
  ) u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .clr_rx_rdy(clr_rx_rdy),
    .rx_rdy    (rx_rdy),
    .rx_data   (rx_data)
  );

  bootloader #(
    .q_depth(q_depth)
  ) u_loader (
    .clk       (clk),
    .rst_n     (rst_n),
    .debug     (debug),
    .rx_rdy    (rx_rdy),
    .rx_data   (rx_data),
    .clr_rx_rdy(clr_rx_rdy),
    .trmt      (trmt),
    .tx_data   (tx_data),
    .tx_done   (tx_done),
    .outdata   (outdata),
    .write     (write),
    .addr      (addr),
    .data      (data),
    .increment (increment)
  );

  uart_tx #(
    .clks_per_bit(clks_per_bit)
  ) u_tx (
    .clk    (clk),
    .rst_n  (rst_n),
    .trmt   (trmt),
    .tx_data(tx_data),
    .tx     (tx),
    .tx_done(tx_done)
  );

endmodule

// ==== bench/boot_checker.sv ====
`timescale 1ns/1ps

module boot_checker (
  input logic                        clk,
  input logic                        rst_n,
  input logic                        debug,
  input logic                        increment,
  input logic                        clr_rx_rdy,
  input logic                        trmt,
  input logic                        tx_done,
  input logic [boot_pkg::word_w-1:0] addr,
  input boot_pkg::send_state_t       send_state
);

  a_inc_single: assert property (@(posedge clk) disable iff (!rst_n)
    increment |=> !increment)
    else $error("increment stayed high for two cycles");

  a_addr_step: assert property (@(posedge clk) disable iff (!rst_n)
    (increment && debug) ##1 debug |-> addr == $past(addr) + 32'd1)
    else $error("addr did not advance by one after increment");

  // first byte from SPLIT, the others on tx_done.
  a_trmt_src: assert property (@(posedge clk) disable iff (!rst_n)
    trmt |-> (send_state == boot_pkg::SPLIT) ||
             (send_state == boot_pkg::SEND && tx_done))
    else $error("trmt pulsed outside SPLIT or tx_done");

  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !trmt && !increment && !clr_rx_rdy)
    else $error("strobe active while in reset");

endmodule

bind bootloader boot_checker u_checker (
  .clk       (clk),
  .rst_n     (rst_n),
  .debug     (debug),
  .increment (increment),
  .clr_rx_rdy(clr_rx_rdy),
  .trmt      (trmt),
  .tx_done   (tx_done),
  .addr      (addr),
  .send_state(send_state)
);

// ==== bench/boot_tb.sv ====
`timescale 1ns/1ps

module boot_tb;

  localparam int clks_per_bit = 8;
  localparam int q_depth = 8;
  localparam int n_load = 4;
  localparam int n_tx = 3;
  // rx frames of all load tests plus tx frames at 10 bits each.
  localparam int n_frames = 4 * n_load + 4 + 4 + 1 + 4 + 4 * n_tx + 4 * q_depth;
  localparam int max_cycles = n_frames * 10 * clks_per_bit + 2000;

  logic        clk;
  logic        rst_n;
  logic        debug;
  logic        rx;
  logic        tx;
  logic [31:0] outdata;
  logic        write;
  logic [31:0] addr;
  logic [31:0] data;
  logic        increment;

  logic [31:0] load_word [n_load] = '{32'h0000_0013, 32'h00a0_0093, 32'hdead_beef,
                                      32'h1234_5678};
  logic [31:0] load_addr [n_load] = '{32'd0, 32'd1, 32'd2, 32'd3};
  logic [31:0] tx_word [n_tx] = '{32'h8bad_f00d, 32'h0102_0304, 32'hffff_0000};

  logic [31:0] inc_addr [$];   // addr seen at each increment.
  logic [31:0] inc_data [$];
  logic [7:0]  tx_bytes [$];   // bytes decoded from tx.
  logic [31:0] sent_words [$];
  integer      seed;
  int          cycles = 0;

  boot_top #(
    .clks_per_bit(clks_per_bit),
    .q_depth     (q_depth)
  ) UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .debug    (debug),
    .rx       (rx),
    .tx       (tx),
    .outdata  (outdata),
    .write    (write),
    .addr     (addr),
    .data     (data),
    .increment(increment)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display(">>> FAIL");
      $fatal(1);
    end
  end

  always @(negedge clk) begin
    if (rst_n === 1'b1 && increment === 1'b1) begin
      inc_addr.push_back(addr);
      inc_data.push_back(data);
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
      $display(">>> FAIL");
      $fatal(1);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic send_byte(input logic [7:0] b, input logic stop);
    logic [9:0] frame;
    frame = {stop, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #1 rx = frame[i];
      repeat (clks_per_bit - 1) @(posedge clk);
    end
    @(posedge clk);
    #1 rx = 1'b1; // back to idle.
  endtask

  task automatic send_word(input logic [31:0] w);
    for (int j = 0; j < 4; j++)
      send_byte(w[8*j +: 8], 1'b1);
  endtask

  task automatic receive_byte(output logic [7:0] b);
    @(negedge clk);
    while (tx !== 1'b0)
      @(negedge clk);
    repeat (clks_per_bit / 2) @(negedge clk); // middle of start bit.
    check_value("tx start bit", tx, 32'd0);
    for (int i = 0; i < 8; i++) begin
      repeat (clks_per_bit) @(negedge clk);
      b[i] = tx;
    end
    repeat (clks_per_bit) @(negedge clk);
    check_value("tx stop bit", tx, 32'd1);
  endtask

  task automatic push_word(input logic [31:0] w);
    @(posedge clk);
    #1 write = 1'b1;
    outdata = w;
    @(posedge clk);
    #1 write = 1'b0;
    sent_words.push_back(w);
  endtask

  task automatic expect_load(input logic [31:0] w, input logic [31:0] a);
    while (inc_data.size() < 1)
      @(posedge clk);
    check_value("data", inc_data[0], w);
    check_value("addr", inc_addr[0], a);
    inc_data.delete();
    inc_addr.delete();
  endtask

  task automatic compare_tx_words();
    logic [31:0] w;
    while (tx_bytes.size() < 4 * sent_words.size())
      @(posedge clk);
    for (int k = 0; k < sent_words.size(); k++) begin
      w = sent_words[k];
      for (int j = 0; j < 4; j++)
        check_value("tx byte", tx_bytes[4*k+j], w[8*j +: 8]); // lsb first.
    end
    tx_bytes.delete();
    sent_words.delete();
  endtask

  initial begin
    logic [7:0] b;
    forever begin
      receive_byte(b);
      tx_bytes.push_back(b);
    end
  end

  initial begin
    logic [31:0] w;
    rst_n = 1'b0;
    debug = 1'b0;
    rx = 1'b1;
    outdata = '0;
    write = 1'b0;
    seed = 32'h85cb_ad30;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;

    @(negedge clk);
    check_value("increment", increment, 32'd0);
    check_value("addr", addr, 32'd0);
    check_value("data", data, 32'd0);
    check_value("tx", tx, 32'd1);

    @(posedge clk);
    #1 debug = 1'b1;
    for (int i = 0; i < n_load; i++)
      send_word(load_word[i]);
    while (inc_data.size() < n_load)
      @(posedge clk);
    for (int i = 0; i < n_load; i++) begin
      check_value("data", inc_data[i], load_word[i]);
      check_value("addr", inc_addr[i], load_addr[i]);
    end
    inc_data.delete();
    inc_addr.delete();

    @(posedge clk);
    #1 debug = 1'b0;
    send_word(32'hcafe_f00d);
    wait_cycles(20);
    check_value("increment count", inc_data.size(), 32'd0);
    @(negedge clk);
    check_value("addr", addr, 32'd0);
    // the receiver still holds the last byte and a short debug pulse lets the loader drop it.
    @(posedge clk);
    #1 debug = 1'b1;
    @(posedge clk);
    #1 debug = 1'b0;
    @(posedge clk);
    #1 debug = 1'b1;
    send_word(32'h0bad_c0de);
    expect_load(32'h0bad_c0de, 32'd0);

    send_byte(8'h3c, 1'b0); // framing error.
    wait_cycles(2 * clks_per_bit);
    @(negedge clk);
    check_value("data", data, 32'h0bad_c0de); // a dropped frame leaves data alone.
    send_word(32'h7654_3210);
    expect_load(32'h7654_3210, 32'd1);

    for (int i = 0; i < n_tx; i++)
      push_word(tx_word[i]);
    compare_tx_words();

    for (int i = 0; i < q_depth; i++) begin
      w = $random(seed);
      @(posedge clk);
      #1 write = 1'b1;
      outdata = w;
      sent_words.push_back(w);
    end
    @(posedge clk);
    #1 write = 1'b0;
    compare_tx_words();

    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== tb.f ====
verilog/boot_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/word_fifo.sv
verilog/bootloader.sv
verilog/boot_top.sv
bench/boot_checker.sv
bench/boot_tb.sv

// ==== Bender.yml ====
package:
  name: boot_loader

sources:
  - files:
      - verilog/boot_pkg.sv
      - verilog/uart_rx.sv
      - verilog/uart_tx.sv
      - verilog/word_fifo.sv
      - verilog/bootloader.sv
      - verilog/boot_top.sv
  - target: simulation
    files:
      - bench/boot_checker.sv
      - bench/boot_tb.sv
